// File: verilog/uartBridge_defines.svh
// Bridge constants; BIT_CLKS must be even and at least 4, MEM_WORDS must be a power of two
`ifndef UARTBRIDGE_DEFINES_SVH
`define UARTBRIDGE_DEFINES_SVH

// Clocks per serial bit, shared by receiver and transmitter
`define BIT_CLKS 16

// Depth of the on-chip word memory
// Address is taken modulo this depth
`define MEM_WORDS 256

// Command opcodes, first byte of a frame
`define CMD_READ 8'h52
`define CMD_WRITE 8'h57

// Abort byte, drops a partial command
`define CMD_CLEAR 8'h2F

`endif

// File: verilog/uartBridge_pkg.sv
// Frame types for the command parser; bytes are packed opcode first, so byte 0 sits in [47:40]
package uartBridge_pkg;

    typedef logic [22:0] memAddr_t;    // Word address, 23 bits
    typedef logic [15:0] memWord_t;    // One memory word

    // Read view: R, three address bytes, then two bytes never received
    typedef struct packed {
        logic [7:0]  opcode;           // Always CMD_READ here
        logic        addrTop;          // Bit 23 of the address bytes, ignored
        memAddr_t    addr;
        logic [15:0] pad;              // Stale, not part of a read
    } readFrame_s;

    // Write view: W, three address bytes, data high then low
    typedef struct packed {
        logic [7:0]  opcode;           // Always CMD_WRITE here
        logic        addrTop;          // Ignored like in the read view
        memAddr_t    addr;
        memWord_t    data;             // High byte received first
    } writeFrame_s;

    // One 48-bit register, decoded by whichever opcode arrived
    typedef union packed {
        readFrame_s  rd;
        writeFrame_s wr;
    } cmdFrame_u;

endpackage

// File: verilog/memBus_if.sv
// Parser-to-memory bus; all strobes are one cycle wide and there is no back-pressure
`timescale 1ns/1ps

interface memBus_if;
    import uartBridge_pkg::*;

    // Request side, driven by the parser
    logic     reqValid;    // One-cycle request strobe
    logic     reqWrite;    // 1 write, 0 read
    memAddr_t reqAddr;     // Full word address, memory wraps it
    memWord_t reqData;     // Only meaningful on writes

    // Read return, driven by the memory
    logic     rdValid;     // One cycle after a read request
    memWord_t rdData;

    // Command parser end
    modport master (
        output reqValid, reqWrite, reqAddr, reqData,
        input  rdValid, rdData
    );

    // Memory end
    modport slave (
        input  reqValid, reqWrite, reqAddr, reqData,
        output rdValid, rdData
    );

endinterface

// File: verilog/uartRx.sv
// 8N1 receiver, LSB first; stop bit is not checked, a start glitch shorter than half a bit is dropped
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module uartRx (
    input  logic       sys_clk,
    input  logic       arstN,
    input  logic       rxLine,
    output logic [7:0] rxByte,
    output logic       rxStrobe
);
    localparam int CNT_W = $clog2(`BIT_CLKS);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`BIT_CLKS / 2);    // Middle of start bit
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`BIT_CLKS - 1);

    // FSM states
    localparam logic [2:0] RX_IDLE  = 3'd0;
    localparam logic [2:0] RX_START = 3'd1;
    localparam logic [2:0] RX_WAIT  = 3'd2;
    localparam logic [2:0] RX_READ  = 3'd3;
    localparam logic [2:0] RX_STOP  = 3'd4;

    logic [1:0]       syncReg;     // Two-flop synchronizer
    logic             rxSync;
    logic [2:0]       state;
    logic [CNT_W-1:0] clkCnt;      // Clocks inside current bit
    logic [2:0]       bitCnt;      // Data bits taken so far

    assign rxSync = syncReg[1];

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            syncReg  <= 2'b11;     // Line idles high
            state    <= RX_IDLE;
            clkCnt   <= '0;
            bitCnt   <= '0;
            rxStrobe <= 1'b0;
        end else begin
            syncReg  <= {syncReg[0], rxLine};
            rxStrobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rxSync) begin             // First low sample is the start bit
                        state  <= RX_START;
                        clkCnt <= CNT_W'(1);       // This clock counts
                        bitCnt <= '0;
                    end
                end
                RX_START: begin
                    if (clkCnt == HALF_CNT) begin
                        state  <= rxSync ? RX_IDLE : RX_WAIT;    // High again means a glitch
                        clkCnt <= CNT_W'(1);
                    end else
                        clkCnt <= clkCnt + 1'b1;
                end
                RX_WAIT: begin
                    if (clkCnt == LAST_CNT)
                        state <= RX_READ;          // Next clock is mid-bit
                    else
                        clkCnt <= clkCnt + 1'b1;
                end
                RX_READ: begin
                    clkCnt <= CNT_W'(1);
                    bitCnt <= bitCnt + 3'd1;
                    state  <= (bitCnt == 3'd7) ? RX_STOP : RX_WAIT;
                end
                RX_STOP: begin
                    if (clkCnt == LAST_CNT) begin
                        state    <= RX_IDLE;       // Back in idle at stop-bit middle
                        rxStrobe <= 1'b1;
                    end else
                        clkCnt <= clkCnt + 1'b1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data shift register, LSB arrives first
    always_ff @(posedge sys_clk) begin
        if (state == RX_READ)
            rxByte <= {rxSync, rxByte[7:1]};
    end

endmodule

// File: verilog/uartTx.sv
// Sends one word as two 8N1 bytes, low byte first; a sendStrobe while busy is ignored
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module uartTx (
    input  logic                    sys_clk,
    input  logic                    arstN,
    input  logic                    sendStrobe,
    input  uartBridge_pkg::memWord_t sendWord,
    output logic                    txLine
);
    import uartBridge_pkg::*;

    localparam int CNT_W = $clog2(`BIT_CLKS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`BIT_CLKS - 1);

    // FSM states
    localparam logic [1:0] TX_IDLE  = 2'd0;
    localparam logic [1:0] TX_START = 2'd1;
    localparam logic [1:0] TX_DATA  = 2'd2;
    localparam logic [1:0] TX_STOP  = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] clkCnt;      // Clocks inside current bit
    logic [2:0]       bitCnt;      // Data bit on the line
    logic             byteSel;     // 0 low byte, 1 high byte
    memWord_t         txWord;      // Latched reply word
    logic [7:0]       curByte;
    logic             bitEnd;      // Last clock of a bit

    assign curByte = byteSel ? txWord[15:8] : txWord[7:0];
    assign bitEnd  = (clkCnt == LAST_CNT);

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            state   <= TX_IDLE;
            clkCnt  <= '0;
            bitCnt  <= '0;
            byteSel <= 1'b0;
            txLine  <= 1'b1;       // Idle high
        end else begin
            if (state != TX_IDLE)
                clkCnt <= bitEnd ? '0 : clkCnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clkCnt <= '0;
                    if (sendStrobe) begin
                        state   <= TX_START;
                        byteSel <= 1'b0;
                        txLine  <= 1'b0;           // Start bit from next cycle
                    end
                end
                TX_START: begin
                    if (bitEnd) begin
                        state  <= TX_DATA;
                        bitCnt <= '0;
                        txLine <= curByte[0];      // LSB first
                    end
                end
                TX_DATA: begin
                    if (bitEnd) begin
                        if (bitCnt == 3'd7) begin
                            state  <= TX_STOP;
                            txLine <= 1'b1;
                        end else begin
                            bitCnt <= bitCnt + 3'd1;
                            txLine <= curByte[bitCnt + 3'd1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bitEnd) begin
                        if (byteSel)
                            state <= TX_IDLE;      // Both bytes out, line stays high
                        else begin
                            byteSel <= 1'b1;       // High byte next
                            state   <= TX_START;
                            txLine  <= 1'b0;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Word captured only when a frame can start
    always_ff @(posedge sys_clk) begin
        if (state == TX_IDLE && sendStrobe)
            txWord <= sendWord;
    end

endmodule

// File: verilog/cmdParser.sv
// R/W command decoder; byte 0x2F aborts a partial command at any position, so frames must avoid it
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module cmdParser (
    input  logic       sys_clk,
    input  logic       arstN,
    input  logic [7:0] rxByte,
    input  logic       rxStrobe,
    memBus_if.master   mem,
    output logic       cmdError
);
    import uartBridge_pkg::*;

    logic [2:0] byteCnt;       // Bytes of the current command held so far
    cmdFrame_u  frame;         // Collected bytes, opcode on top
    cmdFrame_u  nextFrame;     // Frame with the incoming byte merged in
    logic       isWriteCmd;    // Opcode of the held frame is W
    logic [2:0] lastIdx;       // Index of the final byte
    logic       lastByte;
    logic       isClear;
    logic       isOpcode;      // Known command byte
    logic       frameDone;     // Final byte arriving now

    // Slot for byte n is [47-8n -: 8]
    always_comb begin
        nextFrame = frame;
        nextFrame[47 - 8 * byteCnt -: 8] = rxByte;
    end

    assign isWriteCmd = (frame.wr.opcode == `CMD_WRITE);
    assign lastIdx    = isWriteCmd ? 3'd5 : 3'd3;     // 6 bytes for W, 4 for R
    assign lastByte   = (byteCnt == lastIdx);
    assign isClear    = (rxByte == `CMD_CLEAR);
    assign isOpcode   = (rxByte == `CMD_READ) || (rxByte == `CMD_WRITE);
    assign frameDone  = rxStrobe && (byteCnt != 3'd0) && lastByte && !isClear;

    // Byte counter and strobes
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            byteCnt      <= '0;
            mem.reqValid <= 1'b0;
            cmdError     <= 1'b0;
        end else begin
            mem.reqValid <= 1'b0;          // One-cycle strobes
            cmdError     <= 1'b0;
            if (rxStrobe) begin
                if (isClear) begin
                    byteCnt <= '0;         // Drop partial command
                end else if (byteCnt == 3'd0) begin
                    if (isOpcode)
                        byteCnt <= 3'd1;
                    else
                        cmdError <= 1'b1;  // Unknown opcode is discarded
                end else if (lastByte) begin
                    byteCnt      <= '0;
                    mem.reqValid <= 1'b1;  // Request on the cycle after the last byte
                end else begin
                    byteCnt <= byteCnt + 3'd1;
                end
            end
        end
    end

    // Frame storage and request payload
    always_ff @(posedge sys_clk) begin
        if (rxStrobe)
            frame <= nextFrame;
        if (frameDone) begin
            mem.reqWrite <= isWriteCmd;
            mem.reqAddr  <= nextFrame.rd.addr;    // Address sits in the same bits for R and W
            if (isWriteCmd)
                mem.reqData <= nextFrame.wr.data;    // Write view holds data in the last two bytes
        end
    end

endmodule

// File: verilog/wordStore.sv
// On-chip word memory, zeroed by reset; address wraps modulo MEM_WORDS, reads answer one cycle later
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module wordStore (
    input logic     sys_clk,
    input logic     arstN,
    memBus_if.slave mem
);
    import uartBridge_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    memWord_t         memArr [`MEM_WORDS];    // Storage
    logic [IDX_W-1:0] idx;
    logic             rdReq;
    logic             wrReq;

    assign idx   = mem.reqAddr[IDX_W-1:0];   // Modulo depth, upper bits alias
    assign rdReq = mem.reqValid && !mem.reqWrite;
    assign wrReq = mem.reqValid && mem.reqWrite;

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `MEM_WORDS; i++)
                memArr[i] <= '0;
            mem.rdValid <= 1'b0;
        end else begin
            mem.rdValid <= rdReq;         // Exactly one cycle after the request
            if (wrReq)
                memArr[idx] <= mem.reqData;
        end
    end

    // Read data held until the next read
    always_ff @(posedge sys_clk) begin
        if (rdReq)
            mem.rdData <= memArr[idx];
    end

endmodule

// File: verilog/uartBridgeTop.sv
// UART to word-memory bridge top; the reply word goes out as soon as the memory returns it
`timescale 1ns/1ps

module uartBridgeTop (
    input  logic sys_clk,
    input  logic arstN,
    input  logic uartRxLine,
    output logic uartTxLine,
    output logic cmdError
);
    logic [7:0] rxByte;        // Received byte
    logic       rxStrobe;      // One cycle per byte

    memBus_if memBus ();       // Parser to memory

    // Serial in
    uartRx rxUnit (
        .sys_clk  (sys_clk),
        .arstN    (arstN),
        .rxLine   (uartRxLine),
        .rxByte   (rxByte),
        .rxStrobe (rxStrobe)
    );

    cmdParser parser (
        .sys_clk  (sys_clk),
        .arstN    (arstN),
        .rxByte   (rxByte),
        .rxStrobe (rxStrobe),
        .mem      (memBus.master),
        .cmdError (cmdError)
    );

    wordStore store (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .mem     (memBus.slave)
    );

    // Read return drives the transmitter directly
    uartTx txUnit (
        .sys_clk    (sys_clk),
        .arstN      (arstN),
        .sendStrobe (memBus.rdValid),
        .sendWord   (memBus.rdData),
        .txLine     (uartTxLine)
    );

endmodule

// File: verif/uartBridge_checker.sv
// Bound into uartBridgeTop; one reply in flight at a time, tx window sized for a two-byte frame
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module uartBridge_checker (
    input logic sys_clk,
    input logic arstN,
    input logic rxStrobe,
    input logic reqValid,
    input logic reqWrite,
    input logic rdValid,
    input logic cmdError,
    input logic uartTxLine
);
    localparam int TX_CLKS = 20 * `BIT_CLKS + 2;    // Two frames plus start latency

    int unsigned assertFails = 0;    // Failed assertion count, read at end of run
    int          txWindow;           // Clocks left in the current reply

    // Reply window opens on each read return
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN)
            txWindow <= 0;
        else if (rdValid)
            txWindow <= TX_CLKS;
        else if (txWindow != 0)
            txWindow <= txWindow - 1;
    end

    rxPulse: assert property (@(posedge sys_clk) disable iff (!arstN) rxStrobe |=> !rxStrobe)
        else begin
            assertFails++;
            $error("rxStrobe held longer than one cycle");
        end

    reqPulse: assert property (@(posedge sys_clk) disable iff (!arstN) reqValid |=> !reqValid)
        else begin
            assertFails++;
            $error("reqValid held longer than one cycle");
        end

    errPulse: assert property (@(posedge sys_clk) disable iff (!arstN) cmdError |=> !cmdError)
        else begin
            assertFails++;
            $error("cmdError held longer than one cycle");
        end

    // Covers both directions, so rdValid is a single pulse too
    rdFollows: assert property (@(posedge sys_clk) disable iff (!arstN)
            rdValid == $past(reqValid && !reqWrite))
        else begin
            assertFails++;
            $error("rdValid not exactly one cycle after a read request");
        end

    txIdle: assert property (@(posedge sys_clk) disable iff (!arstN)
            (txWindow == 0 && !rdValid) |-> uartTxLine)
        else begin
            assertFails++;
            $error("uartTxLine low outside a reply");
        end

endmodule

bind uartBridgeTop uartBridge_checker checks (
    .sys_clk    (sys_clk),
    .arstN      (arstN),
    .rxStrobe   (rxStrobe),
    .reqValid   (memBus.reqValid),
    .reqWrite   (memBus.reqWrite),
    .rdValid    (memBus.rdValid),
    .cmdError   (cmdError),
    .uartTxLine (uartTxLine)
);

// File: verif/uartBridge_tb.sv
// Golden file path is relative to the project root; one command and reply at a time, 24-bit addresses
`timescale 1ns/1ps
`include "uartBridge_defines.svh"

module uartBridge_tb;
    import uartBridge_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;                 // Input change after the rising edge
    localparam int RESET_CYCLES = 5;
    localparam int REPLY_WAIT   = 60 * `BIT_CLKS;    // Clocks allowed before a start bit
    localparam int QUIET_CLKS   = 12 * `BIT_CLKS;    // Must stay idle after W, C and E
    localparam logic [7:0] KIND_CLEAR = 8'h43;       // 'C'
    localparam logic [7:0] KIND_BAD   = 8'h45;       // 'E'

    logic sys_clk    = 1'b0;
    logic arstN      = 1'b0;
    logic uartRxLine = 1'b1;    // Idle high
    logic uartTxLine;
    logic cmdError;

    logic [23:0] golden [0:63];    // Count word, then four words per test
    int          numTests;
    int          watchLimit;       // Watchdog time in ns
    int          errors    = 0;
    int          errPulses = 0;    // cmdError pulses seen so far

    uartBridgeTop i_dut (
        .sys_clk    (sys_clk),
        .arstN      (arstN),
        .uartRxLine (uartRxLine),
        .uartTxLine (uartTxLine),
        .cmdError   (cmdError)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    always @(negedge sys_clk) begin
        if (cmdError === 1'b1)
            errPulses++;    // Sampled mid-cycle, away from the edge
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One 8N1 frame, LSB first, each bit BIT_CLKS clocks
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        repeat (10) begin
            @(posedge sys_clk);
            #DRIVE_DLY;
            uartRxLine = bits[0];
            bits = bits >> 1;
            repeat (`BIT_CLKS - 1) @(posedge sys_clk);
        end
    endtask

    task automatic sendCommand(input logic [7:0] kind, input logic [23:0] addr,
                               input memWord_t data);
        if (kind == KIND_BAD) begin
            sendByte(data[7:0]);    // Lone opcode byte
        end else begin
            sendByte((kind == `CMD_READ) ? `CMD_READ : `CMD_WRITE);
            sendByte(addr[23:16]);    // Address MSB first
            sendByte(addr[15:8]);
            sendByte(addr[7:0]);
            if (kind == `CMD_WRITE) begin
                sendByte(data[15:8]);
                sendByte(data[7:0]);
            end else if (kind == KIND_CLEAR)
                sendByte(`CMD_CLEAR);    // Abort the partial write
        end
    endtask

    // Rebuild the reply word, low byte first on the line
    task automatic receiveWord(output memWord_t word, output logic ok);
        int         waited;
        logic [7:0] byteVal;
        ok   = 1'b1;
        word = '0;
        for (int b = 0; b < 2; b++) begin
            waited = 0;
            while (ok && uartTxLine === 1'b1 && waited < REPLY_WAIT) begin
                @(negedge sys_clk);
                waited++;
            end
            if (waited >= REPLY_WAIT)
                ok = 1'b0;
            if (ok) begin
                repeat (`BIT_CLKS / 2) @(negedge sys_clk);    // Middle of start bit
                if (uartTxLine !== 1'b0)
                    ok = 1'b0;
                repeat (8) begin
                    repeat (`BIT_CLKS) @(negedge sys_clk);
                    byteVal = {uartTxLine, byteVal[7:1]};
                end
                repeat (`BIT_CLKS) @(negedge sys_clk);
                if (uartTxLine !== 1'b1)
                    ok = 1'b0;    // Stop bit missing
                word = (b == 0) ? {8'h00, byteVal} : {byteVal, word[7:0]};
            end
        end
    endtask

    task automatic watchQuiet(output logic sawReply);
        sawReply = 1'b0;
        repeat (QUIET_CLKS) begin
            @(negedge sys_clk);
            if (uartTxLine !== 1'b1)
                sawReply = 1'b1;
        end
    endtask

    task automatic compareWord(input int testNum, input string sigName,
                               input memWord_t got, input memWord_t exp);
        if (got !== exp) begin
            $display("MISMATCH test %0d %s got 0x%h expected 0x%h", testNum, sigName, got, exp);
            errors++;
        end else
            $display("test %0d ok %s = 0x%h", testNum, sigName, got);
    endtask

    task automatic compareFlag(input int testNum, input string sigName,
                               input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH test %0d %s got 0x%h expected 0x%h", testNum, sigName, got, exp);
            errors++;
        end else
            $display("test %0d ok %s = 0x%h", testNum, sigName, got);
    endtask

    // Watchdog, 80 bit times per test plus slack for reset
    initial begin
        #1;
        #(watchLimit);
        $display("Watchdog expired at %0t, run did not finish", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [5:0]  row;
        logic [7:0]  kind;
        logic [23:0] addr;
        memWord_t    data;
        memWord_t    expVal;
        memWord_t    gotWord;
        logic        gotOk;
        logic        sawReply;
        int          errBefore;
        int          errorsBefore;
        int          failedTests;
        int          assertCount;
        logic [31:0] rngState;
        rngState    = 32'd42;
        failedTests = 0;
        $readmemh("verif/uartBridge_golden.txt", golden);
        numTests   = int'(golden[0]);
        watchLimit = (numTests * 80 + 100) * `BIT_CLKS * CLK_PERIOD;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #DRIVE_DLY;
        arstN = 1'b1;
        repeat (4) @(posedge sys_clk);
        for (int t = 0; t < numTests; t++) begin
            row          = 6'(4 * t + 1);
            kind         = golden[row][7:0];
            addr         = golden[row + 6'd1];
            data         = golden[row + 6'd2][15:0];
            expVal       = golden[row + 6'd3][15:0];
            errBefore    = errPulses;
            errorsBefore = errors;
            if (kind == `CMD_READ) begin
                fork
                    sendCommand(kind, addr, data);
                    receiveWord(gotWord, gotOk);
                join
                if (gotOk)
                    compareWord(t, "uartTxLine word", gotWord, expVal);
                else begin
                    $display("test %0d no complete reply on uartTxLine for address 0x%h", t, addr);
                    errors++;
                end
            end else if (kind == `CMD_WRITE || kind == KIND_CLEAR || kind == KIND_BAD) begin
                sendCommand(kind, addr, data);
                watchQuiet(sawReply);
                if (sawReply) begin
                    $display("test %0d uartTxLine sent a reply where none belongs", t);
                    errors++;
                end
                compareFlag(t, "cmdError", errPulses != errBefore, expVal[0]);
            end else begin
                $display("test %0d unknown kind 0x%h in golden data", t, kind);
                errors++;
            end
            if (errors != errorsBefore)
                failedTests++;
            rngState = xorshift32(rngState);
            repeat (int'(rngState[1:0]) * `BIT_CLKS) @(posedge sys_clk);    // Idle gap
        end
        assertCount = int'(i_dut.checks.assertFails);
        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 numTests, numTests - failedTests, failedTests, assertCount);
        if (failedTests == 0 && assertCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/uartBridge_pkg.sv
verilog/memBus_if.sv
verilog/uartRx.sv
verilog/uartTx.sv
verilog/cmdParser.sv
verilog/wordStore.sv
verilog/uartBridgeTop.sv
verif/uartBridge_checker.sv
verif/uartBridge_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run from the project root, pass only on the testbench pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module uartBridge_tb -f flist.f -o simv \
    || { echo "RESULT: build error"; exit 1; }
out=$(./obj_dir/simv +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test completed successfully" \
    && echo "RESULT: pass" \
    || { echo "RESULT: fail"; exit 1; }

// File: verif/uartBridge_golden.txt
// First word is the number of tests, then one test per line
// kind (52 R, 57 W, 43 C partial then clear, 45 E bad opcode in data), address, data, expected
F
57 000010 A5C3 0000
52 000010 0000 A5C3
52 000033 0000 0000
57 000145 1E7D 0000
52 000045 0000 1E7D
43 000010 0000 0000
52 000010 0000 A5C3
45 000000 0041 0001
52 000045 0000 1E7D
57 000001 1111 0000
57 000002 C0DE 0000
57 0000FE 8001 0000
52 000001 0000 1111
52 000002 0000 C0DE
52 0000FE 0000 8001
